// ==== csr_fcsr_file.sv ====
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_fcsr_file (
    input  logic                    clk,
    input  logic                    reset,
    input  csr_pkg::csr_write_cmd_t write_cmd,
    input  csr_pkg::fpu_flags_t     fpu_flags,
    input  csr_pkg::wid_t           read_wid,
    output csr_pkg::fcsr_u          read_fcsr,
    input  csr_pkg::wid_t           fpu_frm_wid,
    output csr_pkg::frm_t           fpu_frm
);

    csr_pkg::fcsr_u fcsr_regs [`CSR_NUM_WARPS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `CSR_NUM_WARPS; w++) begin
                fcsr_regs[w] <= '0;
            end
        end else begin
            if (fpu_flags.enable) begin
                fcsr_regs[fpu_flags.wid].fields.fflags <=
                    fcsr_regs[fpu_flags.wid].fields.fflags | fpu_flags.fflags;
            end
            // Later assignments override the FPU OR on the same warp
            if (write_cmd.fflags) begin
                fcsr_regs[write_cmd.wid].fields.fflags <=
                    write_cmd.data[`CSR_FFLAGS_BITS-1:0];
            end
            if (write_cmd.frm) begin
                fcsr_regs[write_cmd.wid].fields.frm <= write_cmd.data[`CSR_FRM_BITS-1:0];
            end
            if (write_cmd.fcsr) begin
                fcsr_regs[write_cmd.wid].word <=
                    write_cmd.data[`CSR_FRM_BITS+`CSR_FFLAGS_BITS-1:0];
            end
        end
    end

    assign read_fcsr = fcsr_regs[read_wid];
    assign fpu_frm   = fcsr_regs[fpu_frm_wid].fields.frm;

endmodule

// ==== csr_machine_regs.sv ====
`timescale 1ns/1ps

module csr_machine_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  csr_pkg::csr_write_cmd_t write_cmd,
    output csr_pkg::machine_csrs_t  regs
);

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else begin
            if (write_cmd.machine_sel.satp) begin
                regs.satp <= write_cmd.data;
            end
            if (write_cmd.machine_sel.mstatus) begin
                regs.mstatus <= write_cmd.data;
            end
            if (write_cmd.machine_sel.medeleg) begin
                regs.medeleg <= write_cmd.data;
            end
            if (write_cmd.machine_sel.mideleg) begin
                regs.mideleg <= write_cmd.data;
            end
            if (write_cmd.machine_sel.mie) begin
                regs.mie <= write_cmd.data;
            end
            if (write_cmd.machine_sel.mtvec) begin
                regs.mtvec <= write_cmd.data;
            end
            if (write_cmd.machine_sel.mepc) begin
                regs.mepc <= write_cmd.data;
            end
        end
    end

endmodule

// ==== csr_macros.svh ====
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// Core geometry
`define CSR_NUM_THREADS 4
`define CSR_NUM_WARPS   4
`define CSR_NUM_CORES   2
`define CSR_NT_BITS     2
`define CSR_NW_BITS     2

`define CSR_ADDR_BITS   12
`define CSR_FFLAGS_BITS 5
`define CSR_FRM_BITS    3
`define CSR_CTR_BITS    64

// Floating point and machine CSRs
`define CSR_FFLAGS      12'h001
`define CSR_FRM         12'h002
`define CSR_FCSR        12'h003
`define CSR_SATP        12'h180
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MEDELEG     12'h302
`define CSR_MIDELEG     12'h303
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341

// Counters, low and high halves
`define CSR_MCYCLE      12'hB00
`define CSR_MINSTRET    12'hB02
`define CSR_MCYCLE_H    12'hB80
`define CSR_MINSTRET_H  12'hB82

`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12
`define CSR_MIMPID      12'hF13

// Thread and warp identity
`define CSR_WTID        12'hCC0
`define CSR_LTID        12'hCC1
`define CSR_GTID        12'hCC2
`define CSR_LWID        12'hCC3
`define CSR_GWID        12'hCC4
`define CSR_GCID        12'hCC5
`define CSR_TMASK       12'hCC6

`define CSR_NT          12'hFC0
`define CSR_NW          12'hFC1
`define CSR_NC          12'hFC2

// RV32 with I, M and F
`define CSR_MISA_VALUE  32'h40001120
`define CSR_VENDOR_ID   32'h00000001
`define CSR_ARCH_ID     32'h00000002
`define CSR_IMPL_ID     32'h00000003

`endif

// ==== csr_perf_counters.sv ====
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_perf_counters (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [2:0]            commit_count,
    output csr_pkg::perf_counts_t counts
);

    logic [`CSR_CTR_BITS-1:0] commit_ext;

    assign commit_ext = {{(`CSR_CTR_BITS-3){1'b0}}, commit_count};

    always_ff @(posedge clk) begin
        if (reset) begin
            counts <= '0;
        end else begin
            counts.cycles  <= counts.cycles + 1'b1;
            // Up to one retire per lane each cycle
            counts.instret <= counts.instret + commit_ext;
        end
    end

endmodule

// ==== csr_pkg.sv ====
`include "csr_macros.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_BITS-1:0] csr_addr_t;
    typedef logic [`CSR_NW_BITS-1:0] wid_t;
    typedef logic [`CSR_NUM_THREADS-1:0] tmask_t;
    // Lane 0 sits in the low word
    typedef logic [`CSR_NUM_THREADS-1:0][31:0] lane_data_t;
    typedef logic [`CSR_FFLAGS_BITS-1:0] fflags_t;
    typedef logic [`CSR_FRM_BITS-1:0] frm_t;

    typedef struct packed {
        frm_t    frm;
        fflags_t fflags;
    } fcsr_fields_t;

    // Same 8 bits seen as the full fcsr or as its two fields
    typedef union packed {
        logic [`CSR_FRM_BITS+`CSR_FFLAGS_BITS-1:0] word;
        fcsr_fields_t                              fields;
    } fcsr_u;

    typedef struct packed {
        wid_t      wid;
        tmask_t    tmask;
        csr_addr_t addr;
    } csr_read_req_t;

    typedef struct packed {
        logic       enable;
        wid_t       wid;
        tmask_t     tmask;
        csr_addr_t  addr;
        lane_data_t data;
    } csr_write_req_t;

    typedef struct packed {
        logic    enable;
        wid_t    wid;
        fflags_t fflags;
    } fpu_flags_t;

    typedef struct packed {
        logic satp;
        logic mstatus;
        logic medeleg;
        logic mideleg;
        logic mie;
        logic mtvec;
        logic mepc;
    } machine_sel_t;

    typedef struct packed {
        logic         fflags;
        logic         frm;
        logic         fcsr;
        machine_sel_t machine_sel;
        wid_t         wid;
        logic [31:0]  data;
    } csr_write_cmd_t;

    typedef struct packed {
        logic [31:0] satp;
        logic [31:0] mstatus;
        logic [31:0] medeleg;
        logic [31:0] mideleg;
        logic [31:0] mie;
        logic [31:0] mtvec;
        logic [31:0] mepc;
    } machine_csrs_t;

    typedef struct packed {
        logic [`CSR_CTR_BITS-1:0] cycles;
        logic [`CSR_CTR_BITS-1:0] instret;
    } perf_counts_t;

endpackage

// ==== csr_read_mux.sv ====
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_read_mux #(
    parameter int CORE_ID = 0
) (
    input  csr_pkg::csr_read_req_t read_req,
    input  csr_pkg::fcsr_u         fcsr,
    input  csr_pkg::machine_csrs_t regs,
    input  csr_pkg::perf_counts_t  counts,
    output csr_pkg::lane_data_t    read_data
);

    localparam logic [31:0] CORE_WORD = 32'(CORE_ID);

    logic [31:0] wid_word;
    logic [31:0] gwid_word;
    csr_pkg::lane_data_t wtid;
    csr_pkg::lane_data_t ltid;
    csr_pkg::lane_data_t gtid;

    assign wid_word  = 32'(read_req.wid);
    assign gwid_word = (CORE_WORD << `CSR_NW_BITS) + wid_word;

    // Per-lane identities
    always_comb begin
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            wtid[i] = 32'(i);
            ltid[i] = (wid_word << `CSR_NT_BITS) + 32'(i);
            gtid[i] = (CORE_WORD << (`CSR_NW_BITS + `CSR_NT_BITS)) + ltid[i];
        end
    end

    always_comb begin
        read_data = '0;
        case (read_req.addr)
            `CSR_FFLAGS:     read_data = {`CSR_NUM_THREADS{32'(fcsr.fields.fflags)}};
            `CSR_FRM:        read_data = {`CSR_NUM_THREADS{32'(fcsr.fields.frm)}};
            `CSR_FCSR:       read_data = {`CSR_NUM_THREADS{32'(fcsr.word)}};
            `CSR_WTID:       read_data = wtid;
            `CSR_LTID:       read_data = ltid;
            `CSR_GTID:       read_data = gtid;
            `CSR_LWID:       read_data = {`CSR_NUM_THREADS{wid_word}};
            `CSR_GWID:       read_data = {`CSR_NUM_THREADS{gwid_word}};
            `CSR_GCID:       read_data = {`CSR_NUM_THREADS{CORE_WORD}};
            `CSR_TMASK:      read_data = {`CSR_NUM_THREADS{32'(read_req.tmask)}};
            `CSR_NT:         read_data = {`CSR_NUM_THREADS{32'(`CSR_NUM_THREADS)}};
            `CSR_NW:         read_data = {`CSR_NUM_THREADS{32'(`CSR_NUM_WARPS)}};
            `CSR_NC:         read_data = {`CSR_NUM_THREADS{32'(`CSR_NUM_CORES)}};
            `CSR_MCYCLE:     read_data = {`CSR_NUM_THREADS{counts.cycles[31:0]}};
            `CSR_MCYCLE_H:   read_data = {`CSR_NUM_THREADS{counts.cycles[63:32]}};
            `CSR_MINSTRET:   read_data = {`CSR_NUM_THREADS{counts.instret[31:0]}};
            `CSR_MINSTRET_H: read_data = {`CSR_NUM_THREADS{counts.instret[63:32]}};
            `CSR_SATP:       read_data = {`CSR_NUM_THREADS{regs.satp}};
            `CSR_MSTATUS:    read_data = {`CSR_NUM_THREADS{regs.mstatus}};
            `CSR_MISA:       read_data = {`CSR_NUM_THREADS{`CSR_MISA_VALUE}};
            `CSR_MEDELEG:    read_data = {`CSR_NUM_THREADS{regs.medeleg}};
            `CSR_MIDELEG:    read_data = {`CSR_NUM_THREADS{regs.mideleg}};
            `CSR_MIE:        read_data = {`CSR_NUM_THREADS{regs.mie}};
            `CSR_MTVEC:      read_data = {`CSR_NUM_THREADS{regs.mtvec}};
            `CSR_MEPC:       read_data = {`CSR_NUM_THREADS{regs.mepc}};
            `CSR_MVENDORID:  read_data = {`CSR_NUM_THREADS{`CSR_VENDOR_ID}};
            `CSR_MARCHID:    read_data = {`CSR_NUM_THREADS{`CSR_ARCH_ID}};
            `CSR_MIMPID:     read_data = {`CSR_NUM_THREADS{`CSR_IMPL_ID}};
            // Unknown address reads zero
            default:         read_data = '0;
        endcase
    end

endmodule

// ==== csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit #(
    parameter int CORE_ID = 0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  csr_pkg::csr_read_req_t  read_req,
    output csr_pkg::lane_data_t     read_data,
    input  csr_pkg::csr_write_req_t write_req,
    input  csr_pkg::fpu_flags_t     fpu_flags,
    input  csr_pkg::wid_t           fpu_frm_wid,
    output csr_pkg::frm_t           fpu_frm,
    input  logic [2:0]              commit_count
);

    csr_pkg::csr_write_cmd_t write_cmd;
    csr_pkg::fcsr_u          read_fcsr;
    csr_pkg::machine_csrs_t  machine_regs;
    csr_pkg::perf_counts_t   counts;

    csr_write_decode u_write_decode (
        .write_req (write_req),
        .write_cmd (write_cmd)
    );

    csr_fcsr_file u_fcsr_file (
        .clk         (clk),
        .reset       (reset),
        .write_cmd   (write_cmd),
        .fpu_flags   (fpu_flags),
        .read_wid    (read_req.wid),
        .read_fcsr   (read_fcsr),
        .fpu_frm_wid (fpu_frm_wid),
        .fpu_frm     (fpu_frm)
    );

    csr_machine_regs u_machine_regs (
        .clk       (clk),
        .reset     (reset),
        .write_cmd (write_cmd),
        .regs      (machine_regs)
    );

    csr_perf_counters u_perf_counters (
        .clk          (clk),
        .reset        (reset),
        .commit_count (commit_count),
        .counts       (counts)
    );

    csr_read_mux #(
        .CORE_ID (CORE_ID)
    ) u_read_mux (
        .read_req  (read_req),
        .fcsr      (read_fcsr),
        .regs      (machine_regs),
        .counts    (counts),
        .read_data (read_data)
    );

endmodule

// ==== csr_unit_properties.sv ====
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_unit_properties (
    input logic                                clk,
    input logic                                reset,
    input csr_pkg::csr_write_cmd_t             write_cmd,
    input csr_pkg::fpu_flags_t                 fpu_flags,
    input logic [`CSR_NUM_WARPS-1:0][7:0]      fcsr_words,
    input logic [`CSR_CTR_BITS-1:0]            cycles
);

    logic             flags_overwritten;
    csr_pkg::fflags_t target_fflags;

    assign flags_overwritten = (write_cmd.fflags || write_cmd.fcsr)
                               && (write_cmd.wid == fpu_flags.wid);
    assign target_fflags = fcsr_words[fpu_flags.wid][`CSR_FFLAGS_BITS-1:0];

    // FPU flags OR into the old value unless a CSR write overrides them
    assert property (@(posedge clk) disable iff (reset)
        fpu_flags.enable && !flags_overwritten
        |=> fcsr_words[$past(fpu_flags.wid)][`CSR_FFLAGS_BITS-1:0]
            == ($past(target_fflags) | $past(fpu_flags.fflags)))
        else $error("fflags did not accumulate the FPU flags");

    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> cycles == $past(cycles) + 64'd1)
        else $error("cycle counter did not advance by one");

    assert property (@(posedge clk) $past(reset) |-> fcsr_words == '0)
        else $error("fcsr not cleared by reset");

endmodule

// Observes the fcsr file and the cycle counter from the top level
bind csr_unit csr_unit_properties props0 (
    .clk        (clk),
    .reset      (reset),
    .write_cmd  (write_cmd),
    .fpu_flags  (fpu_flags),
    .fcsr_words ({u_fcsr_file.fcsr_regs[3], u_fcsr_file.fcsr_regs[2],
                  u_fcsr_file.fcsr_regs[1], u_fcsr_file.fcsr_regs[0]}),
    .cycles     (counts.cycles)
);

// ==== csr_write_decode.sv ====
`timescale 1ns/1ps
`include "csr_macros.svh"

module csr_write_decode (
    input  csr_pkg::csr_write_req_t write_req,
    output csr_pkg::csr_write_cmd_t write_cmd
);

    logic [`CSR_NT_BITS-1:0] lane;

    // Lowest set bit of the thread mask wins
    always_comb begin
        lane = '0;
        for (int i = `CSR_NUM_THREADS - 1; i >= 0; i--) begin
            if (write_req.tmask[i]) begin
                lane = i[`CSR_NT_BITS-1:0];
            end
        end
    end

    always_comb begin
        write_cmd      = '0;
        write_cmd.wid  = write_req.wid;
        write_cmd.data = write_req.data[lane];
        if (write_req.enable) begin
            case (write_req.addr)
                `CSR_FFLAGS:  write_cmd.fflags              = 1'b1;
                `CSR_FRM:     write_cmd.frm                 = 1'b1;
                `CSR_FCSR:    write_cmd.fcsr                = 1'b1;
                `CSR_SATP:    write_cmd.machine_sel.satp    = 1'b1;
                `CSR_MSTATUS: write_cmd.machine_sel.mstatus = 1'b1;
                `CSR_MEDELEG: write_cmd.machine_sel.medeleg = 1'b1;
                `CSR_MIDELEG: write_cmd.machine_sel.mideleg = 1'b1;
                `CSR_MIE:     write_cmd.machine_sel.mie     = 1'b1;
                `CSR_MTVEC:   write_cmd.machine_sel.mtvec   = 1'b1;
                `CSR_MEPC:    write_cmd.machine_sel.mepc    = 1'b1;
                // Read-only or unknown, no strobe
                default: ;
            endcase
        end
    end

endmodule

// ==== project.f ====
+incdir+.
csr_pkg.sv
csr_write_decode.sv
csr_fcsr_file.sv
csr_machine_regs.sv
csr_perf_counters.sv
csr_read_mux.sv
csr_unit.sv
csr_unit_properties.sv
tb_csr_unit.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_csr_unit -f project.f -o sim_csr_unit
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_csr_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb_csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_macros.svh"

module tb_csr_unit;

    localparam int CORE_ID = 1;
    localparam logic [11:0] FP_ADDRS [3] = '{`CSR_FFLAGS, `CSR_FRM, `CSR_FCSR};
    localparam logic [11:0] M_ADDRS [7] = '{`CSR_SATP, `CSR_MSTATUS, `CSR_MEDELEG,
        `CSR_MIDELEG, `CSR_MIE, `CSR_MTVEC, `CSR_MEPC};
    // Last entry is an unused address
    localparam logic [11:0] CONST_ADDRS [8] = '{`CSR_MISA, `CSR_MVENDORID, `CSR_MARCHID,
        `CSR_MIMPID, `CSR_NT, `CSR_NW, `CSR_NC, 12'h7C0};
    localparam logic [11:0] ID_ADDRS [7] = '{`CSR_WTID, `CSR_LTID, `CSR_GTID, `CSR_LWID,
        `CSR_GWID, `CSR_GCID, `CSR_TMASK};
    localparam logic [11:0] CTR_ADDRS [4] = '{`CSR_MCYCLE, `CSR_MCYCLE_H, `CSR_MINSTRET,
        `CSR_MINSTRET_H};

    logic                    clk = 1'b0;
    logic                    reset;
    csr_pkg::csr_read_req_t  read_req;
    csr_pkg::lane_data_t     read_data;
    csr_pkg::csr_write_req_t write_req;
    csr_pkg::fpu_flags_t     fpu_flags;
    csr_pkg::wid_t           fpu_frm_wid;
    csr_pkg::frm_t           fpu_frm;
    logic [2:0]              commit_count;

    // Shadow state
    logic [7:0]  fcsr_model [`CSR_NUM_WARPS];
    logic [31:0] mreg_model [7];
    logic [63:0] cycle_model;
    logic [63:0] instret_model;

    logic [31:0] rng_state = 32'd76691;
    string       test_name = "reset_values";
    int          test_checks = 0;
    int          test_errors = 0;
    int          total_checks = 0;
    int          total_errors = 0;
    int          test_count = 0;
    logic        run_done = 1'b0;

    csr_unit #(.CORE_ID(CORE_ID)) dut0 (
        .clk          (clk),
        .reset        (reset),
        .read_req     (read_req),
        .read_data    (read_data),
        .write_req    (write_req),
        .fpu_flags    (fpu_flags),
        .fpu_frm_wid  (fpu_frm_wid),
        .fpu_frm      (fpu_frm),
        .commit_count (commit_count)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Low LCG bits have short periods so only high halves are used
    task automatic draw(output logic [31:0] value);
        logic [31:0] first;
        first = lcg_step(rng_state);
        rng_state = lcg_step(first);
        value = {first[31:16], rng_state[31:16]};
    endtask

    function automatic csr_pkg::lane_data_t expected_read(input csr_pkg::csr_read_req_t req);
        logic [31:0]         word;
        csr_pkg::lane_data_t result;
        word = 32'd0;
        for (int m = 0; m < 7; m++) begin
            if (req.addr == M_ADDRS[m]) begin
                word = mreg_model[m];
            end
        end
        case (req.addr)
            `CSR_FFLAGS:     word = {27'd0, fcsr_model[req.wid][4:0]};
            `CSR_FRM:        word = {29'd0, fcsr_model[req.wid][7:5]};
            `CSR_FCSR:       word = {24'd0, fcsr_model[req.wid]};
            `CSR_MISA:       word = `CSR_MISA_VALUE;
            `CSR_MVENDORID:  word = `CSR_VENDOR_ID;
            `CSR_MARCHID:    word = `CSR_ARCH_ID;
            `CSR_MIMPID:     word = `CSR_IMPL_ID;
            `CSR_NT:         word = `CSR_NUM_THREADS;
            `CSR_NW:         word = `CSR_NUM_WARPS;
            `CSR_NC:         word = `CSR_NUM_CORES;
            `CSR_MCYCLE:     word = cycle_model[31:0];
            `CSR_MCYCLE_H:   word = cycle_model[63:32];
            `CSR_MINSTRET:   word = instret_model[31:0];
            `CSR_MINSTRET_H: word = instret_model[63:32];
            `CSR_LWID:       word = 32'(req.wid);
            `CSR_GWID:       word = CORE_ID * 4 + 32'(req.wid);
            `CSR_GCID:       word = CORE_ID;
            `CSR_TMASK:      word = 32'(req.tmask);
            default: ;
        endcase
        for (int lane = 0; lane < `CSR_NUM_THREADS; lane++) begin
            case (req.addr)
                `CSR_WTID: result[lane] = lane;
                `CSR_LTID: result[lane] = 32'(req.wid) * 4 + lane;
                `CSR_GTID: result[lane] = CORE_ID * 16 + 32'(req.wid) * 4 + lane;
                default:   result[lane] = word;
            endcase
        end
        return result;
    endfunction

    task automatic update_model();
        logic [31:0] word;
        int          lane;
        logic        found;
        lane = 0;
        found = 1'b0;
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            if (write_req.tmask[i] && !found) begin
                lane = i;
                found = 1'b1;
            end
        end
        word = write_req.data[lane];
        if (fpu_flags.enable) begin
            fcsr_model[fpu_flags.wid][4:0] |= fpu_flags.fflags;
        end
        // CSR write applied last so it wins over the FPU
        if (write_req.enable) begin
            case (write_req.addr)
                `CSR_FFLAGS: fcsr_model[write_req.wid][4:0] = word[4:0];
                `CSR_FRM:    fcsr_model[write_req.wid][7:5] = word[2:0];
                `CSR_FCSR:   fcsr_model[write_req.wid] = word[7:0];
                default: begin
                    for (int m = 0; m < 7; m++) begin
                        if (write_req.addr == M_ADDRS[m]) begin
                            mreg_model[m] = word;
                        end
                    end
                end
            endcase
        end
        cycle_model += 64'd1;
        instret_model += 64'(commit_count);
    endtask

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        test_checks++;
        total_checks++;
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    // Compare before the edge updates state and then advance the model
    always @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `CSR_NUM_WARPS; w++) begin
                fcsr_model[w] = 8'd0;
            end
            for (int m = 0; m < 7; m++) begin
                mreg_model[m] = 32'd0;
            end
            cycle_model = 64'd0;
            instret_model = 64'd0;
        end else begin
            check_value("read_data", expected_read(read_req), read_data);
            check_value("fpu_frm", {125'd0, fcsr_model[fpu_frm_wid][7:5]}, {125'd0, fpu_frm});
            update_model();
        end
    end

    task automatic step();
        @(negedge clk);
    endtask

    task automatic clear_inputs();
        write_req = '0;
        fpu_flags = '0;
        commit_count = 3'd0;
    endtask

    task automatic random_write(input logic [11:0] addr);
        logic [31:0] r;
        draw(r);
        write_req.enable = 1'b1;
        write_req.addr = addr;
        write_req.wid = r[1:0];
        write_req.tmask = (r[7:4] == 4'd0) ? 4'b1000 : r[7:4];
        for (int i = 0; i < `CSR_NUM_THREADS; i++) begin
            draw(r);
            write_req.data[i] = r;
        end
    endtask

    task automatic random_read(input logic [11:0] addr);
        logic [31:0] r;
        draw(r);
        read_req.addr = addr;
        read_req.wid = r[1:0];
        read_req.tmask = r[7:4];
    endtask

    task automatic end_test();
        $display("Test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
        test_count++;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        logic [31:0] r;
        read_req = '0;
        fpu_frm_wid = '0;
        clear_inputs();
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_name = "reset_values";
        for (int w = 0; w < `CSR_NUM_WARPS; w++) begin
            for (int a = 0; a < 3; a++) begin
                read_req.wid = w[1:0];
                read_req.addr = FP_ADDRS[a];
                step();
            end
        end
        for (int m = 0; m < 7; m++) begin
            read_req.addr = M_ADDRS[m];
            step();
        end
        read_req.addr = `CSR_MCYCLE;
        step();
        end_test();

        test_name = "fcsr_writes";
        for (int n = 0; n < 80; n++) begin
            clear_inputs();
            draw(r);
            if (r[0]) begin
                random_write(FP_ADDRS[r[9:8] % 3]);
            end
            random_read(FP_ADDRS[r[13:12] % 3]);
            step();
        end
        end_test();

        test_name = "fpu_flags";
        for (int n = 0; n < 80; n++) begin
            clear_inputs();
            draw(r);
            fpu_flags.enable = r[0];
            fpu_flags.wid = r[2:1];
            fpu_flags.fflags = r[7:3];
            fpu_frm_wid = r[9:8];
            if (r[10]) begin
                random_write(r[11] ? `CSR_FFLAGS : `CSR_FRM);
                // Same warp as the FPU half of the time
                if (r[12]) begin
                    write_req.wid = fpu_flags.wid;
                end
            end
            random_read(FP_ADDRS[r[15:14] % 3]);
            step();
        end
        end_test();

        test_name = "machine_regs";
        for (int n = 0; n < 80; n++) begin
            clear_inputs();
            draw(r);
            if (r[0]) begin
                random_write((r[3:1] == 3'd7) ? `CSR_MISA : M_ADDRS[r[3:1] % 7]);
            end
            random_read(r[4] ? M_ADDRS[r[7:5] % 7] : CONST_ADDRS[r[7:5]]);
            step();
        end
        end_test();

        test_name = "identity";
        for (int n = 0; n < 40; n++) begin
            clear_inputs();
            draw(r);
            random_read(ID_ADDRS[r[2:0] % 7]);
            step();
        end
        end_test();

        test_name = "counters";
        for (int n = 0; n < 60; n++) begin
            clear_inputs();
            draw(r);
            commit_count = 3'(r[2:0] % 5);
            random_read(CTR_ADDRS[r[5:4]]);
            step();
        end
        end_test();

        run_done = 1'b1;
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        for (int c = 0; c < 1000 && !run_done; c++) begin
            @(negedge clk);
        end
        if (!run_done) begin
            $display("Timeout: the stimulus did not finish within 1000 cycles");
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule
